// ==== source/score_pkg.sv ====
package score_pkg;

    // **************************************************
    // frame geometry
    // **************************************************
    localparam int score_width   = 16;
    localparam int num_digits    = 5;
    localparam int glyph_rows    = 10;
    localparam int glyph_width   = 28;
    localparam int digit_pitch   = 36;
    localparam int left_margin   = 12;  // bit 0 of the units digit
    localparam int frame_width   = 192;
    localparam int words_per_row = 6;
    localparam int frame_base    = 16;  // row r, word w sits at frame_base + 8*r + w

    typedef logic [num_digits-1:0][3:0] bcd_digits_t;  // index 0 is the units digit
    typedef logic [glyph_width-1:0] glyph_row_t;
    typedef logic [frame_width-1:0] frame_row_t;

    // **************************************************
    // bus and internal transfer types
    // **************************************************
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] row;
        logic [2:0] position;
        glyph_row_t glyph;
    } render_wr_t;

    typedef enum logic [1:0] {
        kind_score,
        kind_frame,
        kind_unmapped
    } addr_kind_e;

    typedef enum logic [2:0] {
        st_idle,
        st_convert,
        st_render,
        st_drain,
        st_ack
    } ctrl_state_e;

    // **************************************************
    // font, indexed by digit then row
    // **************************************************
    // glyph bit i lands on frame column base + i, so bit 27 is the leftmost dot
    localparam glyph_row_t digit_font [10][glyph_rows] = '{
        '{  // 0
            28'b0,                             28'b0000000_111111111111_000000000,
            28'b0000_111_000000000000_111_000000, 28'b0_111111_000000000000_111111_000,
            28'b0_111111_000000000000_111111_000, 28'b0_111111_000000000000_111111_000,
            28'b0_111111_000000000000_111111_000, 28'b0000_111_000000000000_111_000000,
            28'b0000000_111111111111_000000000,  28'b0
        },
        '{  // 1
            28'b0,                             28'b00000000_11111111_000000000000,
            28'b00000_11111111111_000000000000,  28'b00_11111_000_111111_000000000000,
            28'b0000000000_111111_000000000000,  28'b0000000000_111111_000000000000,
            28'b0000000000_111111_000000000000,  28'b0000000000_111111_000000000000,
            28'b0_111111111111111111111111_000,  28'b0
        },
        '{  // 2
            28'b0,                             28'b0000000_111111111111_000000000,
            28'b0000_111111_000000_111111_000000, 28'b0000_111_000000000_111111_000000,
            28'b0000000000000_111111_000000000,  28'b0000000000_111111_000000000000,
            28'b0000000_111111_000000000000000,  28'b0000_111111_000000000_111_000000,
            28'b0000_111111111111111111_000000,  28'b0
        },
        '{  // 3
            28'b0,                             28'b00000_1111111111111111_0000000,
            28'b0000_111_000000000_111111_000000, 28'b0000000000000000_111111_000000,
            28'b0000000000000000_111_000000000,  28'b0000000_111111111111111_000000,
            28'b0000000000000000_111111_000000,  28'b0000_111_000000000_111111_000000,
            28'b0000000_111111111111_000000000,  28'b0
        },
        '{  // 4
            28'b0,                             28'b0000000000000000_111_000000000,
            28'b0000000000000_111111_000000000,  28'b0000000000_111_000_111_000000000,
            28'b0000000_111_000000_111_000000000, 28'b0000_111_000000000_111_000000000,
            28'b0000_111111111111111111111_000,  28'b0000000000000000_111_000000000,
            28'b0000000000000000_111_000000000,  28'b0
        },
        '{  // 5
            28'b0,                             28'b0000_111111111111111111_000000,
            28'b0000_111_0000000000000_11_000000, 28'b0000_111_000000000000000000000,
            28'b0000_111111111111111111_000000,  28'b0000_111111111111111111_000000,
            28'b0000000000000000000_111_000000,  28'b0000_111_000000000000_111_000000,
            28'b0000_111111111111111111_000000,  28'b0
        },
        '{  // 6
            28'b0,                             28'b0000_11111111111111111_0000000,
            28'b0000_111_000000000000_11_0000000, 28'b0000_111_000000000000000000000,
            28'b0000_111_000000000000000000000,  28'b0000_111111111111111111_000000,
            28'b0000_111_000000000000_111_000000, 28'b0000_111_000000000000_111_000000,
            28'b0000_111111111111111111_000000,  28'b0
        },
        '{  // 7
            28'b0,                             28'b0000_111111111111111111_000000,
            28'b0000_111_000000000000_111_000000, 28'b0000_111_000000000000_111_000000,
            28'b0000000000000000000_111_000000,  28'b0000000000000000000_111_000000,
            28'b0000000000000000000_111_000000,  28'b0000000000000000000_111_000000,
            28'b0000000000000000000_111_000000,  28'b0
        },
        '{  // 8
            28'b0,                             28'b0000000_111111111111_000000000,
            28'b0000_111_000000000000_111_000000, 28'b0000_111_000000000000_111_000000,
            28'b0000000_111111111111_000000000,  28'b0000_111_000000000000_111_000000,
            28'b0000_111_000000000000_111_000000, 28'b0000_111_000000000000_111_000000,
            28'b0000000_111111111111_000000000,  28'b0
        },
        '{  // 9
            28'b0,                             28'b0000_111111111111111111_000000,
            28'b0000_111_000000000000_111_000000, 28'b0000_111_000000000000_111_000000,
            28'b0000_111111111111111111_000000,  28'b0000000000000000000_111_000000,
            28'b0000000000000000000_111_000000,  28'b0000_111_000000000000_111_000000,
            28'b0000_111111111111111111_000000,  28'b0
        }
    };

endpackage

// ==== source/bin_to_bcd.sv ====
`timescale 1ns/1ps

module bin_to_bcd #(
    parameter int SCORE_WIDTH = 16,
    parameter int NUM_DIGITS  = 5
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [SCORE_WIDTH-1:0]  bin,
    output logic                    done,
    output score_pkg::bcd_digits_t  digits
);

    localparam int cnt_width = $clog2(SCORE_WIDTH + 1);

    logic [SCORE_WIDTH-1:0]      shift_q;
    logic [NUM_DIGITS-1:0][3:0]  bcd_q;
    logic [NUM_DIGITS-1:0][3:0]  bcd_adj;
    logic [cnt_width-1:0]        count_q;  // shifts still to go
    logic                        busy_q;

    // add three to every digit that would overflow when doubled
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            bcd_adj[i] = (bcd_q[i] > 4'd4) ? bcd_q[i] + 4'd3 : bcd_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            done    <= 1'b0;
            count_q <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q  <= 1'b1;
                count_q <= cnt_width'(SCORE_WIDTH);
            end else if (busy_q) begin
                if (count_q != '0) begin
                    count_q <= count_q - 1'b1;
                end else begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;  // one cycle after the last shift
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= bin;
            bcd_q   <= '0;
        end else if (busy_q && count_q != '0) begin
            {bcd_q, shift_q} <= {bcd_adj, shift_q} << 1;
        end
        if (busy_q && !start && count_q == '0) begin
            digits <= score_pkg::bcd_digits_t'(bcd_q);  // held until the next conversion ends
        end
    end

endmodule

// ==== source/score_ctrl.sv ====
`timescale 1ns/1ps

module score_ctrl #(
    parameter int SCORE_WIDTH = 16,
    parameter int NUM_DIGITS  = 5
) (
    input  logic                    clk,
    input  logic                    rst,
    input  score_pkg::wb_req_t      wb_req,
    output score_pkg::wb_rsp_t      wb_rsp,
    output logic                    conv_start,
    output logic [SCORE_WIDTH-1:0]  score,
    input  logic                    conv_done,
    input  score_pkg::bcd_digits_t  digits,
    output logic                    item_valid,
    output logic [3:0]              row,
    output logic [2:0]              position,
    output logic [3:0]              digit,
    output logic [3:0]              rd_row,
    output logic [2:0]              rd_word,
    input  logic [31:0]             rd_data
);

    localparam logic [7:0] frame_lo = 8'(score_pkg::frame_base);
    localparam logic [7:0] frame_hi = 8'(score_pkg::frame_base + 8 * score_pkg::glyph_rows);

    score_pkg::ctrl_state_e  state_q;
    score_pkg::addr_kind_e   kind;
    logic                    req;
    logic [7:0]              frame_off;
    logic [3:0]              row_q;
    logic [2:0]              pos_q;
    logic [SCORE_WIDTH-1:0]  score_q;
    logic                    start_q;
    logic [31:0]             rsp_dat_q;
    logic                    last_pos;
    logic                    last_row;

    assign req       = wb_req.cyc && wb_req.stb;
    assign frame_off = wb_req.adr - frame_lo;
    assign rd_row    = frame_off[6:3];
    assign rd_word   = frame_off[2:0];

    always_comb begin
        if (wb_req.adr == 8'd0) begin
            kind = score_pkg::kind_score;
        end else if (wb_req.adr >= frame_lo && wb_req.adr < frame_hi &&
                     rd_word < 3'(score_pkg::words_per_row)) begin
            kind = score_pkg::kind_frame;
        end else begin
            kind = score_pkg::kind_unmapped;  // includes words 6 and 7 of each row
        end
    end

    assign last_pos = (pos_q == 3'(NUM_DIGITS - 1));
    assign last_row = (row_q == 4'(score_pkg::glyph_rows - 1));

    // **************************************************
    // control FSM
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= score_pkg::st_idle;
            start_q <= 1'b0;
            score_q <= '0;
            row_q   <= '0;
            pos_q   <= '0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                score_pkg::st_idle: begin
                    if (req && wb_req.we && kind == score_pkg::kind_score) begin
                        score_q <= wb_req.dat[SCORE_WIDTH-1:0];
                        start_q <= 1'b1;
                        state_q <= score_pkg::st_convert;
                    end else if (req) begin
                        state_q <= score_pkg::st_ack;  // reads and ignored writes
                    end
                end
                score_pkg::st_convert: begin
                    if (conv_done) begin
                        row_q   <= '0;
                        pos_q   <= '0;
                        state_q <= score_pkg::st_render;
                    end
                end
                score_pkg::st_render: begin
                    if (last_pos) begin
                        pos_q <= '0;
                        row_q <= row_q + 4'd1;
                    end else begin
                        pos_q <= pos_q + 3'd1;
                    end
                    if (last_pos && last_row) begin
                        state_q <= score_pkg::st_drain;
                    end
                end
                // the last renderer write lands at the end of this cycle
                score_pkg::st_drain: state_q <= score_pkg::st_ack;
                default:             state_q <= score_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == score_pkg::st_idle && req) begin
            case (kind)
                score_pkg::kind_score: rsp_dat_q <= 32'(score_q);
                score_pkg::kind_frame: rsp_dat_q <= rd_data;
                default:               rsp_dat_q <= '0;
            endcase
        end
    end

    assign wb_rsp     = '{ack: (state_q == score_pkg::st_ack) && req, dat: rsp_dat_q};
    assign conv_start = start_q;
    assign score      = score_q;
    assign item_valid = (state_q == score_pkg::st_render);
    assign row        = row_q;
    assign position   = pos_q;
    assign digit      = digits[pos_q];

endmodule

// ==== source/glyph_renderer.sv ====
`timescale 1ns/1ps

module glyph_renderer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  item_valid,
    input  logic [3:0]            row,
    input  logic [2:0]            position,
    input  logic [3:0]            digit,
    output score_pkg::render_wr_t wr
);

    score_pkg::glyph_row_t  glyph;
    score_pkg::glyph_row_t  glyph_q;
    logic                   valid_q;
    logic [3:0]             row_q;
    logic [2:0]             pos_q;

    // anything outside the font draws blank
    always_comb begin
        glyph = '0;
        if (digit < 4'd10 && row < 4'(score_pkg::glyph_rows)) begin
            glyph = score_pkg::digit_font[digit][row];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= item_valid;
        end
    end

    always_ff @(posedge clk) begin
        glyph_q <= glyph;
        row_q   <= row;
        pos_q   <= position;
    end

    assign wr = '{valid: valid_q, row: row_q, position: pos_q, glyph: glyph_q};

endmodule

// ==== source/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  score_pkg::render_wr_t wr,
    input  logic [3:0]            rd_row,
    input  logic [2:0]            rd_word,
    output logic [31:0]           rd_data
);

    score_pkg::frame_row_t rows_q [score_pkg::glyph_rows];

    // each write touches only the 28 columns of one digit position
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < score_pkg::glyph_rows; i++) begin
                rows_q[i] <= '0;
            end
        end else if (wr.valid && wr.row < 4'(score_pkg::glyph_rows) &&
                     wr.position < 3'(score_pkg::num_digits)) begin
            rows_q[wr.row][score_pkg::left_margin + wr.position * score_pkg::digit_pitch
                           +: score_pkg::glyph_width] <= wr.glyph;
        end
    end

    // **************************************************
    // word read
    // **************************************************
    always_comb begin
        rd_data = '0;
        if (rd_row < 4'(score_pkg::glyph_rows) && rd_word < 3'(score_pkg::words_per_row)) begin
            rd_data = rows_q[rd_row][rd_word * 32 +: 32];  // word w is columns 32w up
        end
    end

endmodule

// ==== source/score_render_top.sv ====
`timescale 1ns/1ps

module score_render_top (
    input  logic               clk,
    input  logic               rst,
    input  score_pkg::wb_req_t wb_req,
    output score_pkg::wb_rsp_t wb_rsp
);

    localparam int SCORE_WIDTH = score_pkg::score_width;
    localparam int NUM_DIGITS  = score_pkg::num_digits;

    logic                    conv_start;
    logic [SCORE_WIDTH-1:0]  score;
    logic                    conv_done;
    score_pkg::bcd_digits_t  digits;
    logic                    item_valid;
    logic [3:0]              row;
    logic [2:0]              position;
    logic [3:0]              digit;
    score_pkg::render_wr_t   wr;
    logic [3:0]              rd_row;
    logic [2:0]              rd_word;
    logic [31:0]             rd_data;

    score_ctrl #(
        .SCORE_WIDTH (SCORE_WIDTH),
        .NUM_DIGITS  (NUM_DIGITS)
    ) u_score_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .conv_start (conv_start),
        .score      (score),
        .conv_done  (conv_done),
        .digits     (digits),
        .item_valid (item_valid),
        .row        (row),
        .position   (position),
        .digit      (digit),
        .rd_row     (rd_row),
        .rd_word    (rd_word),
        .rd_data    (rd_data)
    );

    bin_to_bcd #(
        .SCORE_WIDTH (SCORE_WIDTH),
        .NUM_DIGITS  (NUM_DIGITS)
    ) u_bin_to_bcd (
        .clk    (clk),
        .rst    (rst),
        .start  (conv_start),
        .bin    (score),
        .done   (conv_done),
        .digits (digits)
    );

    // one item per cycle in, one placed glyph row per cycle out
    glyph_renderer u_glyph_renderer (
        .clk        (clk),
        .rst        (rst),
        .item_valid (item_valid),
        .row        (row),
        .position   (position),
        .digit      (digit),
        .wr         (wr)
    );

    frame_buffer u_frame_buffer (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .rd_row  (rd_row),
        .rd_word (rd_word),
        .rd_data (rd_data)
    );

endmodule

// ==== test/score_model.svh ====
`ifndef score_model_svh
`define score_model_svh

// **************************************************
// reference model of the rendered frame
// **************************************************

// decimal digits by repeated division, units digit at index 0
function automatic score_pkg::bcd_digits_t model_digits(
    input logic [score_pkg::score_width-1:0] s
);
    score_pkg::bcd_digits_t d;
    int unsigned            v;
    v = s;
    for (int i = 0; i < score_pkg::num_digits; i++) begin
        d[i] = 4'(v % 10);
        v = v / 10;
    end
    return d;
endfunction

// one full frame row with every digit placed at its column
function automatic score_pkg::frame_row_t model_row(
    input logic [score_pkg::score_width-1:0] s,
    input int                                r
);
    score_pkg::frame_row_t  row;
    score_pkg::bcd_digits_t d;
    int                     col;
    row = '0;
    d = model_digits(s);
    for (int p = 0; p < score_pkg::num_digits; p++) begin
        col = score_pkg::left_margin + p * score_pkg::digit_pitch;  // units digit sits lowest
        row[col +: score_pkg::glyph_width] = score_pkg::digit_font[d[p]][r];
    end
    return row;
endfunction

// word w covers columns 32w to 32w+31
function automatic logic [31:0] model_word(
    input logic [score_pkg::score_width-1:0] s,
    input int                                r,
    input int                                w
);
    score_pkg::frame_row_t row;
    row = model_row(s, r);
    return row[32 * w +: 32];
endfunction

function automatic logic [7:0] frame_addr(input int r, input int w);
    return 8'(score_pkg::frame_base + 8 * r + w);
endfunction

`endif

// ==== test/tb_score_render.sv ====
`timescale 1ns/1ps

module tb_score_render;

    localparam int num_directed = 5;
    localparam int num_random   = 40;
    localparam int frame_words  = score_pkg::glyph_rows * score_pkg::words_per_row;
    // reset reads, then one write, one score read and a full frame per score, then extras
    localparam int num_transactions = 1 + frame_words +
                                      (num_directed + num_random + 1) * (2 + frame_words) + 20;
    localparam int worst_write_cycles = score_pkg::score_width + 1 + 50 + 1 + 8;
    localparam int timeout_cycles = num_transactions * worst_write_cycles + 1000;

    logic               clk;
    logic               rst;
    score_pkg::wb_req_t wb_req;
    score_pkg::wb_rsp_t wb_rsp;

    logic [31:0] lcg_state;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    score_render_top u_score_render_top (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    `include "score_model.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // **************************************************
    // bus access and compare tasks
    // **************************************************
    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!wb_rsp.ack) begin
            @(negedge clk);
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;  // next call waits a full cycle, so stb sits low in between
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_score(input string name, input logic [score_pkg::score_width-1:0] got,
                               input logic [score_pkg::score_width-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp);
        end
    endtask

    task automatic check_frame(input logic [score_pkg::score_width-1:0] s, input logic blank);
        logic [31:0] rdat;
        logic [31:0] exp;
        for (int r = 0; r < score_pkg::glyph_rows; r++) begin
            for (int w = 0; w < score_pkg::words_per_row; w++) begin
                bus_read(frame_addr(r, w), rdat);
                exp = blank ? 32'h0 : model_word(s, r, w);
                check_word($sformatf("frame row %0d word %0d", r, w), rdat, exp);
            end
        end
    endtask

    task automatic write_and_verify(input logic [score_pkg::score_width-1:0] s);
        logic [31:0] rdat;
        bus_write(8'd0, 32'(s));
        bus_read(8'd0, rdat);
        check_score("score", rdat[score_pkg::score_width-1:0], s);
        check_word("score upper bits", rdat >> score_pkg::score_width, 32'h0);
        check_frame(s, 1'b0);
    endtask

    // ack must never show up without a live request
    always @(negedge clk) begin
        if (!rst && wb_rsp.ack && !(wb_req.cyc && wb_req.stb)) begin
            other_errors++;
            $display("ack was high at %0t while no request was on the bus", $time);
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        other_errors++;
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        $display("*** FAILED ***");
        $finish;
    end

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        logic [31:0]                       rdat;
        logic [31:0]                       r;
        logic [score_pkg::score_width-1:0] s;
        logic [score_pkg::score_width-1:0] directed [num_directed];

        directed = '{16'd0, 16'd9, 16'd9999, 16'd10000, 16'd65535};
        lcg_state = 32'd37;
        rst = 1'b1;
        wb_req = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (wb_rsp.ack !== 1'b0) begin
            other_errors++;
            $display("ack was not low right after reset");
        end

        bus_read(8'd0, rdat);
        check_score("score after reset", rdat[score_pkg::score_width-1:0], '0);
        check_frame('0, 1'b1);  // nothing rendered yet

        foreach (directed[i]) begin
            write_and_verify(directed[i]);
        end
        for (int i = 0; i < num_random; i++) begin
            r = lcg_next();
            s = r[31 -: score_pkg::score_width];
            write_and_verify(s);
        end

        // unmapped reads, then writes that must change nothing
        bus_read(8'd1, rdat);
        check_word("unmapped 0x01", rdat, 32'h0);
        bus_read(8'd15, rdat);
        check_word("unmapped 0x0f", rdat, 32'h0);
        bus_read(8'(score_pkg::frame_base + 6), rdat);
        check_word("unmapped word 6", rdat, 32'h0);
        bus_read(8'd96, rdat);
        check_word("unmapped 0x60", rdat, 32'h0);
        bus_read(8'd184, rdat);  // offset bits alias row 5 word 0, which is never blank
        check_word("unmapped 0xb8", rdat, 32'h0);
        bus_read(8'd255, rdat);
        check_word("unmapped 0xff", rdat, 32'h0);
        bus_write(frame_addr(0, 0), 32'hffff_ffff);
        bus_write(frame_addr(9, 5), 32'h1234_5678);
        bus_write(8'd3, 32'hdead_beef);
        bus_write(8'd200, 32'h0000_0001);
        bus_read(8'd0, rdat);
        check_score("score after ignored writes", rdat[score_pkg::score_width-1:0], s);
        check_frame(s, 1'b0);

        repeat (2) @(posedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
source/score_pkg.sv
source/bin_to_bcd.sv
source/score_ctrl.sv
source/glyph_renderer.sv
source/frame_buffer.sv
source/score_render_top.sv
test/tb_score_render.sv

// ==== Makefile ====
# Verilator build and run for the score renderer testbench
# every variable can be overridden on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_score_render
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= *** PASSED ***

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation result is taken from the log, not from the exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
